/* common/rv_decode_pkg.sv */
package rv_decode_pkg;

    // Major opcodes
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;
    localparam logic [6:0] OPC_ARI_ITYPE = 7'b0010011;
    localparam logic [6:0] OPC_ARI_RTYPE = 7'b0110011;
    localparam logic [6:0] OPC_CSR       = 7'b1110011;

    localparam logic [2:0] FNC_CSRRW = 3'b001;

    localparam logic [2:0] FNC_LB  = 3'b000;
    localparam logic [2:0] FNC_LH  = 3'b001;
    localparam logic [2:0] FNC_LW  = 3'b010;
    localparam logic [2:0] FNC_LBU = 3'b100;
    localparam logic [2:0] FNC_LHU = 3'b101;

    localparam logic [2:0] FNC_SB = 3'b000;
    localparam logic [2:0] FNC_SH = 3'b001;
    localparam logic [2:0] FNC_SW = 3'b010;

    localparam logic [2:0] FNC_BEQ  = 3'b000;
    localparam logic [2:0] FNC_BNE  = 3'b001;
    localparam logic [2:0] FNC_BLT  = 3'b100;
    localparam logic [2:0] FNC_BGE  = 3'b101;
    localparam logic [2:0] FNC_BLTU = 3'b110;
    localparam logic [2:0] FNC_BGEU = 3'b111;

    // addi x0, x0, 0
    localparam logic [31:0] nop_inst = 32'h0000_0013;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J, IMM_NONE} imm_sel_t;
    typedef enum logic [1:0] {TGT_BR, TGT_JAL, TGT_JALR, TGT_NONE} tgt_sel_t;
    typedef enum logic [1:0] {FWD_NONE, FWD_EX, FWD_MEM, FWD_WB} fwd_sel_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        logic [31:0] raw;
        r_fmt_t      r_fmt;
        i_fmt_t      i_fmt;
        s_fmt_t      s_fmt;
        b_fmt_t      b_fmt;
        u_fmt_t      u_fmt;
        j_fmt_t      j_fmt;
    } inst_u;

    typedef struct packed {
        inst_u ex_inst;
        inst_u mem_inst;
        inst_u wb_inst;
    } stage_hist_t;

    typedef struct packed {
        imm_sel_t imm_sel;
        tgt_sel_t tgt_sel;
        fwd_sel_t fwd_sel;
        logic     target_en;
        logic     stall;
    } ctrl_t;

endpackage

/* hw/id_control.sv */
`timescale 1ns/1ps

module id_control
    import rv_decode_pkg::*;
(
    input  inst_u       inst,
    input  stage_hist_t hist,
    output ctrl_t       ctrl
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic       has_rs1;
    logic       has_rs2;
    logic       is_store;
    logic       ex_wr;
    logic       mem_wr;
    logic       wb_wr;
    logic       ex_load;
    logic       rs1_loading;

    // x0 never counts as a destination
    function automatic logic writes_rd(input inst_u i);
        logic no_rd_op;
        no_rd_op = (i.r_fmt.opcode == OPC_STORE) || (i.r_fmt.opcode == OPC_BRANCH);
        return !no_rd_op && (i.r_fmt.rd != 5'd0);
    endfunction

    assign opcode   = inst.r_fmt.opcode;
    assign funct3   = inst.r_fmt.funct3;
    assign rs1      = inst.r_fmt.rs1;
    assign rs2      = inst.r_fmt.rs2;
    assign is_store = (opcode == OPC_STORE);

    assign has_rs1 = (opcode != OPC_LUI) && (opcode != OPC_AUIPC) && (opcode != OPC_JAL) &&
                     ((opcode != OPC_CSR) || (funct3 == FNC_CSRRW));
    assign has_rs2 = (opcode == OPC_ARI_RTYPE) || is_store || (opcode == OPC_BRANCH);

    assign ex_wr   = writes_rd(hist.ex_inst);
    assign mem_wr  = writes_rd(hist.mem_inst);
    assign wb_wr   = writes_rd(hist.wb_inst);
    assign ex_load = (hist.ex_inst.r_fmt.opcode == OPC_LOAD);

    // Load in ex has not produced rs1 yet
    assign rs1_loading = ex_load && ex_wr && (rs1 == hist.ex_inst.r_fmt.rd);

    always_comb begin
        ctrl.imm_sel   = IMM_NONE;
        ctrl.tgt_sel   = TGT_NONE;
        ctrl.fwd_sel   = FWD_NONE;
        ctrl.target_en = 1'b0;
        ctrl.stall     = 1'b0;

        // Nearest older writer wins
        if (ex_wr && rs1 == hist.ex_inst.r_fmt.rd) begin
            ctrl.fwd_sel = FWD_EX;
        end else if (mem_wr && rs1 == hist.mem_inst.r_fmt.rd) begin
            ctrl.fwd_sel = FWD_MEM;
        end else if (wb_wr && rs1 == hist.wb_inst.r_fmt.rd) begin
            ctrl.fwd_sel = FWD_WB;
        end

        // Store data is forwarded later so only the address operand counts
        if (ex_load && ex_wr) begin
            if (is_store) begin
                ctrl.stall = (rs1 == hist.ex_inst.r_fmt.rd);
            end else begin
                ctrl.stall = (has_rs1 && rs1 == hist.ex_inst.r_fmt.rd) ||
                             (has_rs2 && rs2 == hist.ex_inst.r_fmt.rd);
            end
        end

        case (opcode)
            OPC_ARI_ITYPE: begin
                ctrl.imm_sel = IMM_I;
            end
            OPC_LOAD: begin
                case (funct3)
                    FNC_LB, FNC_LH, FNC_LW, FNC_LBU, FNC_LHU: ctrl.imm_sel = IMM_I;
                    default: ;
                endcase
            end
            OPC_STORE: begin
                case (funct3)
                    FNC_SB, FNC_SH, FNC_SW: ctrl.imm_sel = IMM_S;
                    default: ;
                endcase
            end
            OPC_BRANCH: begin
                case (funct3)
                    FNC_BEQ, FNC_BNE, FNC_BLT, FNC_BGE, FNC_BLTU, FNC_BGEU: begin
                        ctrl.imm_sel   = IMM_B;
                        ctrl.tgt_sel   = TGT_BR;
                        ctrl.target_en = 1'b1;
                    end
                    default: ;
                endcase
            end
            OPC_JAL: begin
                ctrl.imm_sel   = IMM_J;
                ctrl.tgt_sel   = TGT_JAL;
                ctrl.target_en = 1'b1;
            end
            OPC_JALR: begin
                ctrl.imm_sel   = IMM_I;
                ctrl.tgt_sel   = TGT_JALR;
                ctrl.target_en = !rs1_loading;
            end
            OPC_LUI, OPC_AUIPC: begin
                ctrl.imm_sel = IMM_U;
            end
            default: ;
        endcase
    end

endmodule

/* hw/imm_gen.sv */
`timescale 1ns/1ps

module imm_gen
    import rv_decode_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  inst_u            inst,
    input  imm_sel_t         imm_sel,
    output logic [XLEN-1:0]  imm
);

    logic signed [31:0] imm32;

    always_comb begin
        case (imm_sel)
            IMM_I: imm32 = {{20{inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};
            IMM_S: imm32 = {{20{inst.s_fmt.imm_11_5[6]}}, inst.s_fmt.imm_11_5,
                            inst.s_fmt.imm_4_0};
            IMM_B: imm32 = {{19{inst.b_fmt.imm_12}}, inst.b_fmt.imm_12, inst.b_fmt.imm_11,
                            inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
            IMM_U: imm32 = {inst.u_fmt.imm_31_12, 12'b0};
            IMM_J: imm32 = {{11{inst.j_fmt.imm_20}}, inst.j_fmt.imm_20, inst.j_fmt.imm_19_12,
                            inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};
            default: imm32 = '0;
        endcase
    end

    // Signed cast extends to XLEN
    assign imm = XLEN'(imm32);

endmodule

/* target_gen/target_gen.sv */
`timescale 1ns/1ps

module target_gen
    import rv_decode_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] imm,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] ex_result,
    input  logic [XLEN-1:0] mem_result,
    input  logic [XLEN-1:0] wb_result,
    input  ctrl_t           ctrl,
    output logic [XLEN-1:0] target,
    output logic            target_valid
);

    logic [XLEN-1:0] rs1_fwd;
    logic [XLEN-1:0] base;
    logic [XLEN-1:0] sum;

    always_comb begin
        case (ctrl.fwd_sel)
            FWD_EX:  rs1_fwd = ex_result;
            FWD_MEM: rs1_fwd = mem_result;
            FWD_WB:  rs1_fwd = wb_result;
            default: rs1_fwd = rs1_data;
        endcase
    end

    // Only JALR is register relative
    assign base = (ctrl.tgt_sel == TGT_JALR) ? rs1_fwd : pc;
    assign sum  = base + imm;

    always_comb begin
        if (ctrl.tgt_sel == TGT_JALR) begin
            target = {sum[XLEN-1:1], 1'b0};
        end else begin
            target = sum;
        end
    end

    assign target_valid = ctrl.target_en;

endmodule

/* hw/pipe_tracker.sv */
`timescale 1ns/1ps

module pipe_tracker
    import rv_decode_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  inst_u       inst,
    input  logic        stall,
    output stage_hist_t hist
);

    always_ff @(posedge clk) begin
        if (reset) begin
            hist.ex_inst  <= nop_inst;
            hist.mem_inst <= nop_inst;
            hist.wb_inst  <= nop_inst;
        end else begin
            // Bubble into ex while decode holds
            if (stall) begin
                hist.ex_inst <= nop_inst;
            end else begin
                hist.ex_inst <= inst;
            end
            hist.mem_inst <= hist.ex_inst;
            hist.wb_inst  <= hist.mem_inst;
        end
    end

endmodule

/* hw/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage
    import rv_decode_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            reset,
    input  logic [31:0]     inst,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] ex_result,
    input  logic [XLEN-1:0] mem_result,
    input  logic [XLEN-1:0] wb_result,
    output logic [XLEN-1:0] imm,
    output logic [XLEN-1:0] target,
    output logic            target_valid,
    output logic            stall
);

    inst_u       dec_inst;
    stage_hist_t hist;
    ctrl_t       ctrl;

    assign dec_inst = inst;
    assign stall    = ctrl.stall;

    pipe_tracker pipe_tracker_i (
        .clk   (clk),
        .reset (reset),
        .inst  (dec_inst),
        .stall (ctrl.stall),
        .hist  (hist)
    );

    id_control id_control_i (
        .inst (dec_inst),
        .hist (hist),
        .ctrl (ctrl)
    );

    imm_gen #(.XLEN(XLEN)) imm_gen_i (
        .inst    (dec_inst),
        .imm_sel (ctrl.imm_sel),
        .imm     (imm)
    );

    target_gen #(.XLEN(XLEN)) target_gen_i (
        .pc           (pc),
        .imm          (imm),
        .rs1_data     (rs1_data),
        .ex_result    (ex_result),
        .mem_result   (mem_result),
        .wb_result    (wb_result),
        .ctrl         (ctrl),
        .target       (target),
        .target_valid (target_valid)
    );

endmodule

/* verification/decode_stage_vectors.svh */
`ifndef DECODE_STAGE_VECTORS_SVH
`define DECODE_STAGE_VECTORS_SVH

typedef struct packed {
    logic [31:0] inst;
    logic [31:0] pc;
    logic [31:0] rs1_data;
    logic [31:0] ex_result;
    logic [31:0] mem_result;
    logic [31:0] wb_result;
    logic        stall;
    logic [31:0] imm;
    logic        target_valid;
    logic [31:0] target;
} vector_t;

localparam int NUM_ROWS = 24;

// Each row holds inst, pc, rs1_data, ex_result, mem_result, wb_result,
// then expected stall, imm, target_valid and target (target ignored when not valid)
vector_t vectors [NUM_ROWS] = '{
    // Immediates, branch and JAL targets
    '{'hFFB00093, 'h000, 'h0, 'h0, 'h0, 'h0, 1'b0, 'hFFFFFFFB, 1'b0, 'h0},
    '{'hFE21AC23, 'h004, 'h0, 'h0, 'h0, 'h0, 1'b0, 'hFFFFFFF8, 1'b0, 'h0},
    '{'hFE2088E3, 'h100, 'h0, 'h0, 'h0, 'h0, 1'b0, 'hFFFFFFF0, 1'b1, 'h0F0},
    '{'hFFFFF237, 'h104, 'h0, 'h0, 'h0, 'h0, 1'b0, 'hFFFFF000, 1'b0, 'h0},
    '{'h801FF0EF, 'h200, 'h0, 'h0, 'h0, 'h0, 1'b0, 'hFFFFF800, 1'b1, 'hFFFFFA00},
    // Three writers of x9, then JALR x0, 4(x9) walks ex, mem, wb, none
    '{'h008384B3, 'h204, 'h0, 'h0, 'h0, 'h0, 1'b0, 'h0, 1'b0, 'h0},
    '{'h00100493, 'h208, 'h0, 'h0, 'h0, 'h0, 1'b0, 'h1, 1'b0, 'h0},
    '{'h00200493, 'h20C, 'h0, 'h0, 'h0, 'h0, 1'b0, 'h2, 1'b0, 'h0},
    '{'h00448067, 'h210, 'h40000003, 'h10000001, 'h20000005, 'h30000007,
      1'b0, 'h4, 1'b1, 'h10000004},
    '{'h00448067, 'h214, 'h40000003, 'h10000001, 'h20000005, 'h30000007,
      1'b0, 'h4, 1'b1, 'h20000008},
    '{'h00448067, 'h218, 'h40000003, 'h10000001, 'h20000005, 'h30000007,
      1'b0, 'h4, 1'b1, 'h3000000A},
    '{'h00448067, 'h21C, 'h40000003, 'h10000001, 'h20000005, 'h30000007,
      1'b0, 'h4, 1'b1, 'h40000006},
    // Load-use on ADD, then store with only rs2 matching
    '{'h00052283, 'h220, 'h0, 'h0, 'h0, 'h0, 1'b0, 'h0, 1'b0, 'h0},
    '{'h006285B3, 'h224, 'h0, 'h0, 'h0, 'h0, 1'b1, 'h0, 1'b0, 'h0},
    '{'h006285B3, 'h224, 'h0, 'h0, 'h0, 'h0, 1'b0, 'h0, 1'b0, 'h0},
    '{'h00052283, 'h228, 'h0, 'h0, 'h0, 'h0, 1'b0, 'h0, 1'b0, 'h0},
    '{'h00562223, 'h22C, 'h0, 'h0, 'h0, 'h0, 1'b0, 'h4, 1'b0, 'h0},
    // JALR behind a load of its base register
    '{'h00052683, 'h230, 'h0, 'h0, 'h0, 'h0, 1'b0, 'h0, 1'b0, 'h0},
    '{'h000680E7, 'h234, 'h11, 'h23, 'h8001, 'h35, 1'b1, 'h0, 1'b0, 'h0},
    '{'h000680E7, 'h234, 'h11, 'h23, 'h8001, 'h35, 1'b0, 'h0, 1'b1, 'h8000},
    // x0 destinations
    '{'h00052003, 'h238, 'h0, 'h0, 'h0, 'h0, 1'b0, 'h0, 1'b0, 'h0},
    '{'h00000733, 'h23C, 'h0, 'h0, 'h0, 'h0, 1'b0, 'h0, 1'b0, 'h0},
    '{'h00500013, 'h240, 'h0, 'h0, 'h0, 'h0, 1'b0, 'h5, 1'b0, 'h0},
    '{'h00800067, 'h244, 'h101, 'hDEAD0001, 'hBEEF0003, 'hCAFE0005,
      1'b0, 'h8, 1'b1, 'h108}
};

`endif

/* verification/decode_stage_tb.sv */
`timescale 1ns/1ps

module decode_stage_tb
    import rv_decode_pkg::*;
();

    localparam int XLEN         = 32;
    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 10;

    `include "decode_stage_vectors.svh"

    logic            clk;
    logic            reset;
    logic [31:0]     inst;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] ex_result;
    logic [XLEN-1:0] mem_result;
    logic [XLEN-1:0] wb_result;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] target;
    logic            target_valid;
    logic            stall;

    int error_count;
    int failed_tests;

    decode_stage #(.XLEN(XLEN)) decode_stage_i (
        .clk          (clk),
        .reset        (reset),
        .inst         (inst),
        .pc           (pc),
        .rs1_data     (rs1_data),
        .ex_result    (ex_result),
        .mem_result   (mem_result),
        .wb_result    (wb_result),
        .imm          (imm),
        .target       (target),
        .target_valid (target_valid),
        .stall        (stall)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string field, input int row,
                               input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: row %0d %s is %h, expected %h",
                     $time, row, field, got, exp);
            error_count++;
        end
    endtask

    task automatic drive_row(input int row);
        inst       <= vectors[row].inst;
        pc         <= vectors[row].pc;
        rs1_data   <= vectors[row].rs1_data;
        ex_result  <= vectors[row].ex_result;
        mem_result <= vectors[row].mem_result;
        wb_result  <= vectors[row].wb_result;
    endtask

    task automatic compare_row(input int row);
        check_value("stall", row, {31'b0, stall}, {31'b0, vectors[row].stall});
        check_value("imm", row, imm, vectors[row].imm);
        check_value("target_valid", row, {31'b0, target_valid},
                    {31'b0, vectors[row].target_valid});
        // Target only has meaning when flagged valid
        if (vectors[row].target_valid) begin
            check_value("target", row, target, vectors[row].target);
        end
    endtask

    initial begin
        int errors_before;
        clk          = 1'b0;
        reset        = 1'b1;
        inst         = nop_inst;
        pc           = '0;
        rs1_data     = '0;
        ex_result    = '0;
        mem_result   = '0;
        wb_result    = '0;
        error_count  = 0;
        failed_tests = 0;

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        for (int i = 0; i < NUM_ROWS; i++) begin
            @(posedge clk);
            drive_row(i);
            @(negedge clk);
            errors_before = error_count;
            compare_row(i);
            if (error_count == errors_before) begin
                $display("Test %0d inst %h: ok", i, vectors[i].inst);
            end else begin
                failed_tests++;
                $display("Test %0d inst %h: error", i, vectors[i].inst);
            end
        end

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d mismatches",
                 NUM_ROWS, NUM_ROWS - failed_tests, failed_tests, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Four times the expected run length
    initial begin
        #((NUM_ROWS + RESET_CYCLES) * CLK_PERIOD * 4);
        $display("Timeout: the test sequence did not finish in time");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

/* rv_decode.f */
+incdir+verification
common/rv_decode_pkg.sv
hw/id_control.sv
hw/imm_gen.sv
target_gen/target_gen.sv
hw/pipe_tracker.sv
hw/decode_stage.sv
verification/decode_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module decode_stage_tb \
    -f rv_decode.f -o decode_stage_sim

./obj_dir/decode_stage_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTS PASSED" sim.log; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed, see sim.log"
exit 1
